//--- logic/mul_pkg.sv
// multiply unit shared definitions
// widths, chunk counts and the operation and element-width encodings
`default_nettype none

package mul_pkg;

    ////////////////////
    // vector geometry

    localparam int unsigned VREG_W          = 128;
    // bytes per vector, also number of v0 mask bits
    localparam int unsigned VMSK_W          = 16;
    localparam int unsigned MUL_OP_W        = 32;
    localparam int unsigned CHUNK_BYTES     = 4;
    localparam int unsigned CHUNKS_PER_VREG = 4;
    localparam int unsigned CHUNK_CNT_W     = 2;
    // vl ranges from 0 to 16 elements
    localparam int unsigned VL_W            = 5;

    ////////////////////
    // multiplier lanes

    // 17 bit signed operands, 16 bit accumulator, 33 bit result
    localparam int unsigned LANE_OP_W  = 17;
    localparam int unsigned LANE_ACC_W = 16;
    localparam int unsigned LANE_RES_W = 33;

    ////////////////////
    // encodings

    typedef enum logic [1:0] {
        MUL_VMUL  = 2'd0,
        MUL_VMULH = 2'd1,
        MUL_VMACC = 2'd2
    } mul_op_e;

    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vsew_e;

    typedef struct packed {
        mul_op_e op;
        logic    op1_signed;
        logic    op2_signed;
    } mul_mode_t;

endpackage

`default_nettype wire

//--- logic/mul_chunk_if.sv
// operand chunk channel from sequencer to datapath
// one 32-bit slice of each source vector with mode and byte enables
`timescale 1ns/1ps
`default_nettype none

interface mul_chunk_if
    import mul_pkg::*;
();

    logic                   valid;
    logic                   ready;
    mul_mode_t              mode;
    vsew_e                  eew;
    logic [MUL_OP_W-1:0]    op1;
    logic [MUL_OP_W-1:0]    op2;
    logic [MUL_OP_W-1:0]    acc;
    logic [CHUNK_BYTES-1:0] be;

    modport seq (output valid, mode, eew, op1, op2, acc, be, input ready);

    modport dp (input valid, mode, eew, op1, op2, acc, be, output ready);

endinterface

`default_nettype wire

//--- logic/mul_res_if.sv
// result chunk channel from datapath to collector
`timescale 1ns/1ps
`default_nettype none

interface mul_res_if
    import mul_pkg::*;
();

    logic                   valid;
    logic                   ready;
    logic [MUL_OP_W-1:0]    data;
    logic [CHUNK_BYTES-1:0] be;

    modport dp (output valid, data, be, input ready);

    modport col (input valid, data, be, output ready);

endinterface

`default_nettype wire

//--- logic/mul_sequencer.sv
// multiply unit sequencer
// accepts one operation and issues its vectors as four 32-bit chunks
`timescale 1ns/1ps
`default_nettype none

module mul_sequencer
    import mul_pkg::*;
(
    input  logic              clk_i,
    input  logic              async_rst_ni,

    input  logic              op_valid_i,
    output logic              op_ready_o,
    input  mul_op_e           op_i,
    input  logic              op1_signed_i,
    input  logic              op2_signed_i,
    input  logic              masked_i,
    input  vsew_e             vsew_i,
    input  logic [VL_W-1:0]   vl_i,
    input  logic [VMSK_W-1:0] v0_i,
    input  logic [VREG_W-1:0] vs1_i,
    input  logic [VREG_W-1:0] vs2_i,
    input  logic [VREG_W-1:0] vs3_i,

    mul_chunk_if.seq          chunk
);

    logic                   busy_q;
    logic [CHUNK_CNT_W-1:0] cnt_q;
    mul_mode_t              mode_q;
    vsew_e                  eew_q;
    logic [VREG_W-1:0]      vs1_q;
    logic [VREG_W-1:0]      vs2_q;
    logic [VREG_W-1:0]      vs3_q;
    logic [VMSK_W-1:0]      be_q;
    logic [VMSK_W-1:0]      be_d;
    logic [VL_W-1:0]        elem_idx;
    logic                   last_chunk;
    logic                   issue;
    logic                   accept;

    assign last_chunk = cnt_q == CHUNK_CNT_W'(CHUNKS_PER_VREG - 1);
    assign issue      = busy_q & chunk.ready;
    assign op_ready_o = ~busy_q | (last_chunk & chunk.ready);
    assign accept     = op_valid_i & op_ready_o;

    // byte enables for the whole vector, from vl and v0
    always_comb begin
        be_d     = '0;
        elem_idx = '0;
        for (int b = 0; b < VMSK_W; b++) begin
            unique case (vsew_i)
                VSEW_8:  elem_idx = VL_W'(b);
                VSEW_16: elem_idx = VL_W'(b / 2);
                default: elem_idx = VL_W'(b / 4);
            endcase
            be_d[b] = (elem_idx < vl_i) & (~masked_i | v0_i[elem_idx[3:0]]);
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (issue) begin
            busy_q <= ~last_chunk;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // operands drop one chunk per issue
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mode_q <= '{op: op_i, op1_signed: op1_signed_i, op2_signed: op2_signed_i};
            eew_q  <= vsew_i;
            vs1_q  <= vs1_i;
            vs2_q  <= vs2_i;
            vs3_q  <= vs3_i;
            be_q   <= be_d;
        end else if (issue) begin
            vs1_q  <= vs1_q >> MUL_OP_W;
            vs2_q  <= vs2_q >> MUL_OP_W;
            vs3_q  <= vs3_q >> MUL_OP_W;
            be_q   <= be_q >> CHUNK_BYTES;
        end
    end

    assign chunk.valid = busy_q;
    assign chunk.mode  = mode_q;
    assign chunk.eew   = eew_q;
    assign chunk.op1   = vs1_q[MUL_OP_W-1:0];
    assign chunk.op2   = vs2_q[MUL_OP_W-1:0];
    assign chunk.acc   = vs3_q[MUL_OP_W-1:0];
    assign chunk.be    = be_q[CHUNK_BYTES-1:0];

endmodule

`default_nettype wire

//--- logic/mul_block.sv
// 17x17 signed multiplier with 16-bit accumulator add
// result is registered when enabled
`timescale 1ns/1ps
`default_nettype none

module mul_block
    import mul_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  logic                  en_i,
    input  logic [LANE_OP_W-1:0]  op1_i,
    input  logic [LANE_OP_W-1:0]  op2_i,
    input  logic [LANE_ACC_W-1:0] acc_i,
    output logic [LANE_RES_W-1:0] res_o
);

    logic signed [2*LANE_OP_W-1:0] prod;
    logic        [LANE_RES_W-1:0]  sum;
    logic        [LANE_RES_W-1:0]  res_q;

    assign prod = $signed(op1_i) * $signed(op2_i);

    // accumulator is an unsigned addend
    assign sum = prod[LANE_RES_W-1:0] + {{(LANE_RES_W - LANE_ACC_W){1'b0}}, acc_i};

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            res_q <= '0;
        end else if (en_i) begin
            res_q <= sum;
        end
    end

    assign res_o = res_q;

endmodule

`default_nettype wire

//--- logic/mul_datapath.sv
// multiply unit datapath
// pack, multiply and compose stages on one 32-bit chunk per cycle
`timescale 1ns/1ps
`default_nettype none

module mul_datapath
    import mul_pkg::*;
(
    input  logic     clk_i,
    input  logic     async_rst_ni,
    mul_chunk_if.dp  chunk,
    mul_res_if.dp    res
);

    // stage valid and ready
    logic p_valid_q, m_valid_q, c_valid_q;
    logic m_ready, c_ready;

    logic [MUL_OP_W-1:0] op_a, op_b, acc_src;
    logic                s1, s2;

    logic [CHUNK_BYTES-1:0][LANE_OP_W-1:0]  pk_op1, pk_op2;
    logic [CHUNK_BYTES-1:0][LANE_ACC_W-1:0] pk_acc;
    logic [CHUNK_BYTES-1:0][LANE_OP_W-1:0]  p_op1_q, p_op2_q;
    logic [CHUNK_BYTES-1:0][LANE_ACC_W-1:0] p_acc_q;
    logic [CHUNK_BYTES-1:0][LANE_RES_W-1:0] m_res;

    mul_mode_t              p_mode_q, m_mode_q;
    vsew_e                  p_eew_q, m_eew_q;
    logic [CHUNK_BYTES-1:0] p_be_q, m_be_q, c_be_q;
    logic [MUL_OP_W-1:0]    c_data_q, compose_d;
    logic [2*MUL_OP_W-1:0]  res32;

    assign chunk.ready = ~p_valid_q | m_ready;
    assign m_ready     = ~m_valid_q | c_ready;
    assign c_ready     = ~c_valid_q | res.ready;

    ////////////////////
    // pack stage

    assign op_a    = chunk.op1;
    assign op_b    = chunk.op2;
    assign s1      = chunk.mode.op1_signed;
    assign s2      = chunk.mode.op2_signed;
    assign acc_src = (chunk.mode.op == MUL_VMACC) ? chunk.acc : '0;

    always_comb begin
        pk_op1 = '0;
        pk_op2 = '0;
        pk_acc = '0;
        unique case (chunk.eew)
            VSEW_8: begin
                for (int g = 0; g < CHUNK_BYTES; g++) begin
                    pk_op1[g] = {{(LANE_OP_W - 8){s1 & op_a[8*g+7]}}, op_a[8*g +: 8]};
                    pk_op2[g] = {{(LANE_OP_W - 8){s2 & op_b[8*g+7]}}, op_b[8*g +: 8]};
                    pk_acc[g] = {8'b0, acc_src[8*g +: 8]};
                end
            end
            VSEW_16: begin
                // even lanes only
                for (int h = 0; h < CHUNK_BYTES / 2; h++) begin
                    pk_op1[2*h] = {s1 & op_a[16*h+15], op_a[16*h +: 16]};
                    pk_op2[2*h] = {s2 & op_b[16*h+15], op_b[16*h +: 16]};
                    pk_acc[2*h] = acc_src[16*h +: 16];
                end
            end
            VSEW_32: begin
                // lanes hold lo*lo, hi*lo, lo*hi and hi*hi
                pk_op1[0] = {1'b0, op_a[15:0]};
                pk_op1[1] = {s1 & op_a[31], op_a[31:16]};
                pk_op1[2] = {1'b0, op_a[15:0]};
                pk_op1[3] = {s1 & op_a[31], op_a[31:16]};
                pk_op2[0] = {1'b0, op_b[15:0]};
                pk_op2[1] = {1'b0, op_b[15:0]};
                pk_op2[2] = {s2 & op_b[31], op_b[31:16]};
                pk_op2[3] = {s2 & op_b[31], op_b[31:16]};
                pk_acc[0] = acc_src[15:0];
                pk_acc[1] = acc_src[31:16];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            p_valid_q <= 1'b0;
            m_valid_q <= 1'b0;
            c_valid_q <= 1'b0;
        end else begin
            if (chunk.ready) begin
                p_valid_q <= chunk.valid;
            end
            if (m_ready) begin
                m_valid_q <= p_valid_q;
            end
            if (c_ready) begin
                c_valid_q <= m_valid_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (chunk.ready & chunk.valid) begin
            p_mode_q <= chunk.mode;
            p_eew_q  <= chunk.eew;
            p_be_q   <= chunk.be;
            p_op1_q  <= pk_op1;
            p_op2_q  <= pk_op2;
            p_acc_q  <= pk_acc;
        end
        if (m_ready & p_valid_q) begin
            m_mode_q <= p_mode_q;
            m_eew_q  <= p_eew_q;
            m_be_q   <= p_be_q;
        end
        if (c_ready & m_valid_q) begin
            c_data_q <= compose_d;
            c_be_q   <= m_be_q;
        end
    end

    ////////////////////
    // multiply stage

    for (genvar g = 0; g < CHUNK_BYTES; g++) begin : gen_lane
        mul_block u_mul_block (
            .clk_i        (clk_i),
            .async_rst_ni (async_rst_ni),
            .en_i         (m_ready & p_valid_q),
            .op1_i        (p_op1_q[g]),
            .op2_i        (p_op2_q[g]),
            .acc_i        (p_acc_q[g]),
            .res_o        (m_res[g])
        );
    end

    ////////////////////
    // compose stage

    // partial products of a 32-bit element
    assign res32 = {{(2*MUL_OP_W - LANE_RES_W){m_res[0][LANE_RES_W-1]}}, m_res[0]}
                 + ({{(2*MUL_OP_W - LANE_RES_W){m_res[1][LANE_RES_W-1]}}, m_res[1]} << 16)
                 + ({{(2*MUL_OP_W - LANE_RES_W){m_res[2][LANE_RES_W-1]}}, m_res[2]} << 16)
                 + ({{(2*MUL_OP_W - LANE_RES_W){m_res[3][LANE_RES_W-1]}}, m_res[3]} << 32);

    always_comb begin
        compose_d = '0;
        unique case (m_eew_q)
            VSEW_8: begin
                for (int g = 0; g < CHUNK_BYTES; g++) begin
                    compose_d[8*g +: 8] = (m_mode_q.op == MUL_VMULH) ? m_res[g][15:8]
                                                                     : m_res[g][7:0];
                end
            end
            VSEW_16: begin
                for (int h = 0; h < CHUNK_BYTES / 2; h++) begin
                    compose_d[16*h +: 16] = (m_mode_q.op == MUL_VMULH) ? m_res[2*h][31:16]
                                                                       : m_res[2*h][15:0];
                end
            end
            VSEW_32: begin
                compose_d = (m_mode_q.op == MUL_VMULH) ? res32[63:32] : res32[31:0];
            end
            default: ;
        endcase
    end

    assign res.valid = c_valid_q;
    assign res.data  = c_data_q;
    assign res.be    = c_be_q;

endmodule

`default_nettype wire

//--- logic/mul_collector.sv
// result collector
// gathers four result chunks and holds the vector for the output handshake
`timescale 1ns/1ps
`default_nettype none

module mul_collector
    import mul_pkg::*;
(
    input  logic              clk_i,
    input  logic              async_rst_ni,
    mul_res_if.col            res,
    output logic              res_valid_o,
    input  logic              res_ready_i,
    output logic [VREG_W-1:0] res_data_o,
    output logic [VMSK_W-1:0] res_be_o
);

    logic [VREG_W-1:0]      data_q, out_data_q;
    logic [VMSK_W-1:0]      be_q, out_be_q;
    logic [CHUNK_CNT_W-1:0] cnt_q;
    logic                   full_q;
    logic                   out_valid_q;
    logic                   last_chunk;
    logic                   take;

    assign last_chunk = cnt_q == CHUNK_CNT_W'(CHUNKS_PER_VREG - 1);

    // the fourth chunk waits while the output register is held
    assign res.ready = ~last_chunk | ~out_valid_q | res_ready_i;
    assign take      = res.valid & res.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            cnt_q       <= '0;
            full_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (take) begin
                cnt_q <= cnt_q + 1'b1;
            end
            full_q <= take & last_chunk;
            // a complete vector always finds the output register free
            if (full_q) begin
                out_valid_q <= 1'b1;
            end else if (res_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            data_q <= {res.data, data_q[VREG_W-1:MUL_OP_W]};
            be_q   <= {res.be, be_q[VMSK_W-1:CHUNK_BYTES]};
        end
        if (full_q) begin
            out_data_q <= data_q;
            out_be_q   <= be_q;
        end
    end

    assign res_valid_o = out_valid_q;
    assign res_data_o  = out_data_q;
    assign res_be_o    = out_be_q;

endmodule

`default_nettype wire

//--- logic/mul_unit.sv
// pipelined vector multiply unit
// sequencer, chunk datapath and result collector behind valid/ready ports
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import mul_pkg::*;
(
    input  logic              clk_i,
    input  logic              async_rst_ni,

    input  logic              op_valid_i,
    output logic              op_ready_o,
    input  mul_op_e           op_i,
    input  logic              op1_signed_i,
    input  logic              op2_signed_i,
    input  logic              masked_i,
    input  vsew_e             vsew_i,
    input  logic [VL_W-1:0]   vl_i,
    input  logic [VMSK_W-1:0] v0_i,
    input  logic [VREG_W-1:0] vs1_i,
    input  logic [VREG_W-1:0] vs2_i,
    input  logic [VREG_W-1:0] vs3_i,

    output logic              res_valid_o,
    input  logic              res_ready_i,
    output logic [VREG_W-1:0] res_data_o,
    output logic [VMSK_W-1:0] res_be_o
);

    mul_chunk_if chunk_if ();
    mul_res_if   res_if ();

    mul_sequencer u_sequencer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_valid_i   (op_valid_i),
        .op_ready_o   (op_ready_o),
        .op_i         (op_i),
        .op1_signed_i (op1_signed_i),
        .op2_signed_i (op2_signed_i),
        .masked_i     (masked_i),
        .vsew_i       (vsew_i),
        .vl_i         (vl_i),
        .v0_i         (v0_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vs3_i        (vs3_i),
        .chunk        (chunk_if.seq)
    );

    mul_datapath u_datapath (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .chunk        (chunk_if.dp),
        .res          (res_if.dp)
    );

    mul_collector u_collector (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .res          (res_if.col),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_data_o   (res_data_o),
        .res_be_o     (res_be_o)
    );

endmodule

`default_nettype wire

//--- test/mul_unit_tb.sv
// testbench for the vector multiply unit
// random operations checked against a reference model of the result rules
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb
    import mul_pkg::*;
();

    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int LAT_TIMEOUT   = 40;

    logic              clk_i;
    logic              async_rst_ni;
    logic              op_valid_i;
    logic              op_ready_o;
    mul_op_e           op_i;
    logic              op1_signed_i;
    logic              op2_signed_i;
    logic              masked_i;
    vsew_e             vsew_i;
    logic [VL_W-1:0]   vl_i;
    logic [VMSK_W-1:0] v0_i;
    logic [VREG_W-1:0] vs1_i;
    logic [VREG_W-1:0] vs2_i;
    logic [VREG_W-1:0] vs3_i;
    logic              res_valid_o;
    logic              res_ready_i;
    logic [VREG_W-1:0] res_data_o;
    logic [VMSK_W-1:0] res_be_o;

    int seed       = 66093;
    int ready_seed = 66093;
    int data_errors;
    int be_errors;
    int proto_errors;
    int timeouts;
    logic bp_mode;
    logic timed_out;
    logic was_stalled;
    logic [VREG_W-1:0] hold_data;
    logic [VMSK_W-1:0] hold_be;
    logic [VREG_W-1:0] exp_data_q[$];
    logic [VMSK_W-1:0] exp_be_q[$];

    mul_unit uut (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .op_valid_i   (op_valid_i),
        .op_ready_o   (op_ready_o),
        .op_i         (op_i),
        .op1_signed_i (op1_signed_i),
        .op2_signed_i (op2_signed_i),
        .masked_i     (masked_i),
        .vsew_i       (vsew_i),
        .vl_i         (vl_i),
        .v0_i         (v0_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vs3_i        (vs3_i),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_data_o   (res_data_o),
        .res_be_o     (res_be_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // output back-pressure is random only while bp_mode is set
    initial begin
        logic next_ready;
        forever begin
            @(negedge clk_i);
            next_ready = bp_mode ? 1'($random(ready_seed)) : 1'b1;
            @(posedge clk_i);
            #2;
            res_ready_i = next_ready;
        end
    end

    ////////////////////
    // reference model

    function automatic logic [VMSK_W-1:0] expected_be(vsew_e w, logic [VL_W-1:0] vl,
                                                      logic [VMSK_W-1:0] v0, logic m);
        logic [VMSK_W-1:0] be;
        int eb;
        int e;
        eb = 1 << int'(w);
        be = '0;
        for (int b = 0; b < VMSK_W; b++) begin
            e = b / eb;
            be[b] = (e < vl) && (!m || v0[e]);
        end
        return be;
    endfunction

    function automatic logic [VREG_W-1:0] expected_data(mul_op_e op, logic s1, logic s2,
                                                        vsew_e w, logic [VREG_W-1:0] a,
                                                        logic [VREG_W-1:0] b,
                                                        logic [VREG_W-1:0] c);
        logic [VREG_W-1:0] r;
        logic [63:0] m;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] z;
        logic [63:0] p;
        logic [63:0] elem;
        int ew;
        ew = 8 << int'(w);
        m = (64'd1 << ew) - 1;
        r = '0;
        for (int e = 0; e < VREG_W / ew; e++) begin
            x = 64'(a >> (e * ew)) & m;
            y = 64'(b >> (e * ew)) & m;
            z = 64'(c >> (e * ew)) & m;
            if (s1 && x[ew-1]) x = x | ~m;
            if (s2 && y[ew-1]) y = y | ~m;
            // modulo 2^64 product holds the full double-width result
            p = x * y;
            case (op)
                MUL_VMULH: elem = (p >> ew) & m;
                MUL_VMACC: elem = (p + z) & m;
                default:   elem = p & m;
            endcase
            r = r | (VREG_W'(elem) << (e * ew));
        end
        return r;
    endfunction

    function automatic logic [VREG_W-1:0] byte_mask(logic [VMSK_W-1:0] be);
        logic [VREG_W-1:0] mask;
        for (int b = 0; b < VMSK_W; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

    function automatic logic [VREG_W-1:0] fill_elem(vsew_e w, logic [31:0] val);
        logic [VREG_W-1:0] r;
        int ew;
        ew = 8 << int'(w);
        r = '0;
        for (int e = 0; e < VREG_W / ew; e++) begin
            r = r | ((VREG_W'(val) & ((VREG_W'(1) << ew) - 1)) << (e * ew));
        end
        return r;
    endfunction

    function automatic logic [VREG_W-1:0] rand_vec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    ////////////////////
    // stimulus

    // called at a drive point and returns at the drive point after the accepting edge
    task automatic issue_op(mul_op_e op, logic s1, logic s2, logic m, vsew_e w,
                            logic [VL_W-1:0] vl, logic [VMSK_W-1:0] v0,
                            logic [VREG_W-1:0] a, logic [VREG_W-1:0] b,
                            logic [VREG_W-1:0] c);
        int waited;
        logic done;
        if (!timed_out) begin
            op_valid_i   = 1'b1;
            op_i         = op;
            op1_signed_i = s1;
            op2_signed_i = s2;
            masked_i     = m;
            vsew_i       = w;
            vl_i         = vl;
            v0_i         = v0;
            vs1_i        = a;
            vs2_i        = b;
            vs3_i        = c;
            waited = 0;
            done   = 1'b0;
            while (!done && waited < ISSUE_TIMEOUT) begin
                @(negedge clk_i);
                if (op_ready_o) begin
                    exp_data_q.push_back(expected_data(op, s1, s2, w, a, b, c));
                    exp_be_q.push_back(expected_be(w, vl, v0, m));
                    done = 1'b1;
                end
                @(posedge clk_i);
                #2;
                waited++;
            end
            op_valid_i = 1'b0;
            if (!done) begin
                timeouts++;
                timed_out = 1'b1;
                $display("%0t: timeout, operation was never accepted", $time);
            end
        end
    endtask

    task automatic issue_random_op();
        mul_op_e op;
        vsew_e   w;
        op = mul_op_e'($unsigned($random(seed)) % 3);
        w  = vsew_e'($unsigned($random(seed)) % 3);
        issue_op(op, 1'($random(seed)), 1'($random(seed)), 1'($random(seed)), w,
                 VL_W'($unsigned($random(seed)) % 17), 16'($random(seed)),
                 rand_vec(), rand_vec(), rand_vec());
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while ((exp_data_q.size() > 0 || res_valid_o) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_data_q.size() > 0 || res_valid_o) begin
            timeouts++;
            timed_out = 1'b1;
            $display("%0t: timeout, %0d results never arrived", $time, exp_data_q.size());
        end
        @(posedge clk_i);
        #2;
    endtask

    task automatic measure_latency();
        int cycles;
        logic seen;
        issue_op(MUL_VMUL, 1'b1, 1'b1, 1'b0, VSEW_32, VL_W'(16), '0,
                 rand_vec(), rand_vec(), rand_vec());
        if (!timed_out) begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < LAT_TIMEOUT) begin
                @(posedge clk_i);
                cycles++;
                @(negedge clk_i);
                seen = res_valid_o;
            end
            if (!seen) begin
                timeouts++;
                timed_out = 1'b1;
                $display("%0t: timeout, result of the latency operation never came", $time);
            end else begin
                assert (cycles == 8) else begin
                    proto_errors++;
                    $display("[ERROR] %0t res_valid_o latency expected 8 actual %0d",
                             $time, cycles);
                end
            end
        end
    endtask

    ////////////////////
    // checking

    task automatic check_result();
        logic [VREG_W-1:0] exp_data;
        logic [VREG_W-1:0] mask;
        logic [VMSK_W-1:0] exp_be;
        assert (exp_data_q.size() > 0) else begin
            proto_errors++;
            $display("%0t: result delivered with no operation pending", $time);
        end
        if (exp_data_q.size() > 0) begin
            exp_data = exp_data_q.pop_front();
            exp_be   = exp_be_q.pop_front();
            mask     = byte_mask(exp_be);
            assert (res_be_o === exp_be) else begin
                be_errors++;
                $display("[ERROR] %0t res_be_o expected %h actual %h", $time, exp_be, res_be_o);
            end
            assert ((res_data_o & mask) === (exp_data & mask)) else begin
                data_errors++;
                $display("[ERROR] %0t res_data_o expected %h actual %h",
                         $time, exp_data & mask, res_data_o & mask);
            end
        end
    endtask

    // sampled mid-cycle since the transfer happens on the following edge
    always @(negedge clk_i) begin
        if (!async_rst_ni) begin
            was_stalled = 1'b0;
        end else begin
            if (was_stalled) begin
                assert (res_valid_o) else begin
                    proto_errors++;
                    $display("[ERROR] %0t res_valid_o expected 1 actual %b", $time, res_valid_o);
                end
                assert (res_data_o === hold_data) else begin
                    proto_errors++;
                    $display("[ERROR] %0t res_data_o expected %h actual %h",
                             $time, hold_data, res_data_o);
                end
                assert (res_be_o === hold_be) else begin
                    proto_errors++;
                    $display("[ERROR] %0t res_be_o expected %h actual %h",
                             $time, hold_be, res_be_o);
                end
            end
            if (res_valid_o && res_ready_i) begin
                check_result();
            end
            was_stalled = res_valid_o && !res_ready_i;
            hold_data   = res_data_o;
            hold_be     = res_be_o;
        end
    end

    initial begin
        logic [VREG_W-1:0] a;
        logic [VREG_W-1:0] b;
        logic [VREG_W-1:0] neg;
        int total;
        async_rst_ni = 1'b0;
        op_valid_i   = 1'b0;
        op_i         = MUL_VMUL;
        op1_signed_i = 1'b0;
        op2_signed_i = 1'b0;
        masked_i     = 1'b0;
        vsew_i       = VSEW_8;
        vl_i         = '0;
        v0_i         = '0;
        vs1_i        = '0;
        vs2_i        = '0;
        vs3_i        = '0;
        res_ready_i  = 1'b1;
        bp_mode      = 1'b0;
        timed_out    = 1'b0;
        repeat (5) @(posedge clk_i);
        #2;
        async_rst_ni = 1'b1;

        @(negedge clk_i);
        assert (res_valid_o === 1'b0) else begin
            proto_errors++;
            $display("[ERROR] %0t res_valid_o expected 0 actual %b", $time, res_valid_o);
        end
        assert (op_ready_o === 1'b1) else begin
            proto_errors++;
            $display("[ERROR] %0t op_ready_o expected 1 actual %b", $time, op_ready_o);
        end
        @(posedge clk_i);
        #2;

        // vmul and vmacc at every element width with all bytes enabled
        for (int w = 0; w < 3; w++) begin
            for (int n = 0; n < 6; n++) begin
                issue_op((n % 2 == 1) ? MUL_VMACC : MUL_VMUL, 1'($random(seed)),
                         1'($random(seed)), 1'b0, vsew_e'(w), VL_W'(16), 16'($random(seed)),
                         rand_vec(), rand_vec(), rand_vec());
            end
        end

        // vmulh with every signedness on random and extreme operands
        for (int w = 0; w < 3; w++) begin
            neg = fill_elem(vsew_e'(w), 32'h1 << ((8 << w) - 1));
            for (int s = 0; s < 4; s++) begin
                for (int pat = 0; pat < 4; pat++) begin
                    case (pat)
                        0: begin
                            a = rand_vec();
                            b = rand_vec();
                        end
                        1: begin
                            a = '1;
                            b = '1;
                        end
                        2: begin
                            a = neg;
                            b = neg;
                        end
                        default: begin
                            a = neg;
                            b = '1;
                        end
                    endcase
                    issue_op(MUL_VMULH, s[1], s[0], 1'b0, vsew_e'(w), VL_W'(16), '0,
                             a, b, rand_vec());
                end
            end
        end

        // random vl, v0 and masking
        for (int n = 0; n < 24; n++) begin
            issue_random_op();
        end

        bp_mode = 1'b1;
        for (int n = 0; n < 30; n++) begin
            issue_random_op();
        end
        bp_mode = 1'b0;
        drain_results();

        measure_latency();
        drain_results();

        total = data_errors + be_errors + proto_errors + timeouts;
        $display("errors: data %0d, byte enable %0d, protocol %0d, timeouts %0d",
                 data_errors, be_errors, proto_errors, timeouts);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mul_unit.f
logic/mul_pkg.sv
logic/mul_chunk_if.sv
logic/mul_res_if.sv
logic/mul_sequencer.sv
logic/mul_block.sv
logic/mul_datapath.sv
logic/mul_collector.sv
logic/mul_unit.sv
test/mul_unit_tb.sv

//--- Bender.yml
package:
  name: mul_unit

sources:
  - logic/mul_pkg.sv
  - logic/mul_chunk_if.sv
  - logic/mul_res_if.sv
  - logic/mul_sequencer.sv
  - logic/mul_block.sv
  - logic/mul_datapath.sv
  - logic/mul_collector.sv
  - logic/mul_unit.sv
  - target: test
    files:
      - test/mul_unit_tb.sv
